// ==== logic/reg_bank_pkg.sv ====
// fixed 7-bit address and 8-bit data map; permission bits 7:6 are spare and read as zero
package reg_bank_pkg;

    // ========================================
    // widths and types
    // ========================================
    localparam int REG_AW    = 7;
    localparam int REG_DW    = 8;
    localparam int REG_CRC_W = 8;
    localparam int NUM_REGS  = 8;

    typedef logic [REG_AW-1:0]    reg_addr_t;
    typedef logic [REG_DW-1:0]    reg_data_t;
    typedef logic [REG_CRC_W-1:0] reg_crc_t;
    // mode bits 7..1, bit 0 lives on the hard reset
    typedef logic [REG_DW-2:0]    mode_hi_t;

    // ========================================
    // address map
    // ========================================
    localparam reg_addr_t ADDR_DEVICE_ID = 7'h00;
    localparam reg_addr_t ADDR_MODE      = 7'h01;
    localparam reg_addr_t ADDR_CONFIG1   = 7'h02;
    localparam reg_addr_t ADDR_CONFIG2   = 7'h03;
    localparam reg_addr_t ADDR_STATUS1   = 7'h08;
    localparam reg_addr_t ADDR_MASK1     = 7'h09;
    localparam reg_addr_t ADDR_STATUS2   = 7'h0A;
    localparam reg_addr_t ADDR_MASK2     = 7'h0B;

    // defaults
    localparam logic [3:0] HV_DEVICE_ID = 4'h5;
    localparam logic [3:0] LV_DEVICE_ID = 4'hA;
    localparam reg_data_t  DEVICE_ID    = {HV_DEVICE_ID, LV_DEVICE_ID};
    localparam mode_hi_t   DEF_MODE_HI  = 7'h04;
    localparam reg_data_t  DEF_CONFIG1  = 8'h2B;
    localparam reg_data_t  DEF_CONFIG2  = 8'hFF;
    localparam reg_data_t  DEF_MASK     = 8'h00;

    // ========================================
    // access permissions
    // ========================================
    typedef logic [7:0] reg_perm_t;

    localparam reg_perm_t F_TEST_RD = 8'h01;
    localparam reg_perm_t F_TEST_WR = 8'h02;
    localparam reg_perm_t F_CFG_RD  = 8'h04;
    localparam reg_perm_t F_CFG_WR  = 8'h08;
    localparam reg_perm_t F_SPI_RD  = 8'h10;
    localparam reg_perm_t F_SPI_WR  = 8'h20;

    // every register reads in test and spi mode only
    localparam reg_perm_t F_RD_STD  = F_TEST_RD | F_SPI_RD;

    localparam reg_perm_t PERM_ID     = F_RD_STD;
    localparam reg_perm_t PERM_MODE   = F_RD_STD | F_TEST_WR | F_CFG_WR | F_SPI_WR;
    localparam reg_perm_t PERM_CONFIG = F_RD_STD | F_TEST_WR | F_CFG_WR;
    localparam reg_perm_t PERM_STATUS = F_RD_STD | F_CFG_WR | F_SPI_WR;
    localparam reg_perm_t PERM_MASK   = F_RD_STD | F_TEST_WR | F_CFG_WR;

    // ========================================
    // register indexing
    // ========================================
    typedef logic [NUM_REGS-1:0] reg_sel_t;

    localparam int SEL_ID      = 0;
    localparam int SEL_MODE    = 1;
    localparam int SEL_CONFIG1 = 2;
    localparam int SEL_CONFIG2 = 3;
    localparam int SEL_STATUS1 = 4;
    localparam int SEL_MASK1   = 5;
    localparam int SEL_STATUS2 = 6;
    localparam int SEL_MASK2   = 7;

    localparam reg_addr_t REG_ADDR_MAP [NUM_REGS] = '{
        SEL_ID:      ADDR_DEVICE_ID,
        SEL_MODE:    ADDR_MODE,
        SEL_CONFIG1: ADDR_CONFIG1,
        SEL_CONFIG2: ADDR_CONFIG2,
        SEL_STATUS1: ADDR_STATUS1,
        SEL_MASK1:   ADDR_MASK1,
        SEL_STATUS2: ADDR_STATUS2,
        SEL_MASK2:   ADDR_MASK2
    };

    localparam reg_perm_t REG_PERM_MAP [NUM_REGS] = '{
        SEL_ID:      PERM_ID,
        SEL_MODE:    PERM_MODE,
        SEL_CONFIG1: PERM_CONFIG,
        SEL_CONFIG2: PERM_CONFIG,
        SEL_STATUS1: PERM_STATUS,
        SEL_MASK1:   PERM_MASK,
        SEL_STATUS2: PERM_STATUS,
        SEL_MASK2:   PERM_MASK
    };

endpackage

// ==== logic/rw_reg.sv ====
// no address or permission check here, i_we must already be the granted write select
`timescale 1ns/1ps

module rw_reg #(
    parameter type   T_DATA      = reg_bank_pkg::reg_data_t,
    parameter T_DATA DEFAULT_VAL = '0,
    parameter int    CRC_W       = reg_bank_pkg::REG_CRC_W
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_we,
    input  T_DATA            i_wdata,
    input  logic [CRC_W-1:0] i_wcrc,
    output T_DATA            o_data,
    output logic [CRC_W-1:0] o_crc
);

    T_DATA            data_q;
    logic [CRC_W-1:0] crc_q;

    // value and its crc shadow are written together
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_q <= DEFAULT_VAL;
            crc_q  <= '0;
        end else if (i_we) begin
            data_q <= i_wdata;
            crc_q  <= i_wcrc;
        end
    end

    assign o_data = data_q;
    assign o_crc  = crc_q;

endmodule

// ==== logic/rwc_reg.sv ====
// sticky status bits; a same-cycle set beats a write-1-to-clear
`timescale 1ns/1ps

module rwc_reg (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_we,
    input  reg_bank_pkg::reg_data_t i_wdata,
    input  reg_bank_pkg::reg_data_t i_set,
    output reg_bank_pkg::reg_data_t o_data
);
    import reg_bank_pkg::*;

    reg_data_t status_q;
    reg_data_t clr_mask;
    reg_data_t status_d;

    // ========================================
    // next state
    // ========================================
    always_comb begin
        clr_mask = '0;
        if (i_we) begin
            clr_mask = i_wdata;
        end
        // set applied last so it wins over clear
        status_d = (status_q & ~clr_mask) | i_set;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= status_d;
        end
    end

    assign o_data = status_q;

endmodule

// ==== logic/reg_access_decode.sv ====
// purely combinational; addresses in the map must be unique for one-hot selects
`timescale 1ns/1ps

module reg_access_decode (
    input  logic                    i_ren,
    input  logic                    i_wen,
    input  reg_bank_pkg::reg_addr_t i_addr,
    input  logic                    i_test_en,
    input  logic                    i_cfg_en,
    input  logic                    i_spi_en,
    output reg_bank_pkg::reg_sel_t  o_wr_sel,
    output reg_bank_pkg::reg_sel_t  o_rd_sel
);
    import reg_bank_pkg::*;

    reg_perm_t rd_mask;
    reg_perm_t wr_mask;

    // permission flags opened by the active modes
    always_comb begin
        rd_mask = '0;
        wr_mask = '0;
        if (i_test_en) begin
            rd_mask = rd_mask | F_TEST_RD;
            wr_mask = wr_mask | F_TEST_WR;
        end
        if (i_cfg_en) begin
            rd_mask = rd_mask | F_CFG_RD;
            wr_mask = wr_mask | F_CFG_WR;
        end
        if (i_spi_en) begin
            rd_mask = rd_mask | F_SPI_RD;
            wr_mask = wr_mask | F_SPI_WR;
        end
    end

    // ========================================
    // address match and grant
    // ========================================
    always_comb begin
        o_wr_sel = '0;
        o_rd_sel = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (i_addr == REG_ADDR_MAP[i]) begin
                o_rd_sel[i] = i_ren && ((REG_PERM_MAP[i] & rd_mask) != '0);
                o_wr_sel[i] = i_wen && ((REG_PERM_MAP[i] & wr_mask) != '0);
            end
        end
    end

endmodule

// ==== logic/reg_read_return.sv ====
// one-cycle read latency; zero data and crc when nothing is selected, ack follows every i_ren
`timescale 1ns/1ps

module reg_read_return (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_ren,
    input  reg_bank_pkg::reg_sel_t  i_rd_sel,
    input  reg_bank_pkg::reg_data_t i_mode,
    input  reg_bank_pkg::reg_crc_t  i_mode_crc,
    input  reg_bank_pkg::reg_data_t i_config1,
    input  reg_bank_pkg::reg_crc_t  i_config1_crc,
    input  reg_bank_pkg::reg_data_t i_config2,
    input  reg_bank_pkg::reg_crc_t  i_config2_crc,
    input  reg_bank_pkg::reg_data_t i_status1,
    input  reg_bank_pkg::reg_data_t i_mask1,
    input  reg_bank_pkg::reg_crc_t  i_mask1_crc,
    input  reg_bank_pkg::reg_data_t i_status2,
    input  reg_bank_pkg::reg_data_t i_mask2,
    input  reg_bank_pkg::reg_crc_t  i_mask2_crc,
    output logic                    o_rack,
    output reg_bank_pkg::reg_data_t o_rdata,
    output reg_bank_pkg::reg_crc_t  o_rcrc
);
    import reg_bank_pkg::*;

    reg_data_t rdata_mux;
    reg_crc_t  rcrc_mux;

    // and-or mux over the one-hot select
    // device id and status carry no crc shadow
    always_comb begin
        rdata_mux = ({REG_DW{i_rd_sel[SEL_ID]}}      & DEVICE_ID)
                  | ({REG_DW{i_rd_sel[SEL_MODE]}}    & i_mode)
                  | ({REG_DW{i_rd_sel[SEL_CONFIG1]}} & i_config1)
                  | ({REG_DW{i_rd_sel[SEL_CONFIG2]}} & i_config2)
                  | ({REG_DW{i_rd_sel[SEL_STATUS1]}} & i_status1)
                  | ({REG_DW{i_rd_sel[SEL_MASK1]}}   & i_mask1)
                  | ({REG_DW{i_rd_sel[SEL_STATUS2]}} & i_status2)
                  | ({REG_DW{i_rd_sel[SEL_MASK2]}}   & i_mask2);
        rcrc_mux  = ({REG_CRC_W{i_rd_sel[SEL_MODE]}}    & i_mode_crc)
                  | ({REG_CRC_W{i_rd_sel[SEL_CONFIG1]}} & i_config1_crc)
                  | ({REG_CRC_W{i_rd_sel[SEL_CONFIG2]}} & i_config2_crc)
                  | ({REG_CRC_W{i_rd_sel[SEL_MASK1]}}   & i_mask1_crc)
                  | ({REG_CRC_W{i_rd_sel[SEL_MASK2]}}   & i_mask2_crc);
    end

    // ========================================
    // return stage
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rack  <= 1'b0;
            o_rdata <= '0;
            o_rcrc  <= '0;
        end else begin
            o_rack  <= i_ren;
            o_rdata <= rdata_mux;
            o_rcrc  <= rcrc_mux;
        end
    end

endmodule

// ==== logic/rstn_merge.sv ====
// i_soft_rst must come straight from a flop, it drives the async clear
`timescale 1ns/1ps

module rstn_merge (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_soft_rst,
    output logic o_rst_n
);

    logic       arst_n;
    logic [1:0] sync_q;

    // either source asserts at once
    assign arst_n = i_rst_n & ~i_soft_rst;

    // release on the second edge after both clear
    always_ff @(posedge i_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign o_rst_n = sync_q[1];

endmodule

// ==== logic/reg_bank_top.sv ====
// read data lags i_ren by one cycle, no back-pressure; mode bit 0 holds all other registers in reset
`timescale 1ns/1ps

module reg_bank_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_ren,
    input  logic                   i_wen,
    input  reg_bank_pkg::reg_addr_t i_addr,
    input  reg_bank_pkg::reg_data_t i_wdata,
    input  reg_bank_pkg::reg_crc_t  i_wcrc,
    input  logic                   i_test_en,
    input  logic                   i_cfg_en,
    input  logic                   i_spi_en,
    input  reg_bank_pkg::reg_data_t i_int_status1,
    input  reg_bank_pkg::reg_data_t i_int_status2,
    output logic                   o_wack,
    output logic                   o_rack,
    output reg_bank_pkg::reg_data_t o_rdata,
    output reg_bank_pkg::reg_crc_t  o_rcrc,
    output reg_bank_pkg::reg_data_t o_reg_mode,
    output reg_bank_pkg::reg_data_t o_reg_config1,
    output reg_bank_pkg::reg_data_t o_reg_config2,
    output reg_bank_pkg::reg_data_t o_reg_status1,
    output reg_bank_pkg::reg_data_t o_reg_mask1,
    output reg_bank_pkg::reg_data_t o_reg_status2,
    output reg_bank_pkg::reg_data_t o_reg_mask2,
    output logic                   o_rst_n
);
    import reg_bank_pkg::*;

    // ========================================
    // internal wires
    // ========================================
    logic                 rst_n;
    reg_sel_t             wr_sel;
    reg_sel_t             rd_sel;
    mode_hi_t             mode_hi;
    logic [REG_CRC_W-2:0] mode_hi_crc;
    logic                 mode_lo;
    logic                 mode_lo_crc;
    reg_crc_t             config1_crc;
    reg_crc_t             config2_crc;
    reg_crc_t             mask1_crc;
    reg_crc_t             mask2_crc;

    assign o_wack     = i_wen;
    assign o_reg_mode = {mode_hi, mode_lo};
    assign o_rst_n    = rst_n;

    reg_access_decode u_reg_access_decode (
        .i_ren     (i_ren),
        .i_wen     (i_wen),
        .i_addr    (i_addr),
        .i_test_en (i_test_en),
        .i_cfg_en  (i_cfg_en),
        .i_spi_en  (i_spi_en),
        .o_wr_sel  (wr_sel),
        .o_rd_sel  (rd_sel)
    );

    // ========================================
    // registers
    // ========================================
    rw_reg #(.T_DATA(mode_hi_t), .DEFAULT_VAL(DEF_MODE_HI), .CRC_W(REG_CRC_W-1)) u_mode_hi (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_MODE]),
        .i_wdata (i_wdata[REG_DW-1:1]),
        .i_wcrc  (i_wcrc[REG_CRC_W-1:1]),
        .o_data  (mode_hi),
        .o_crc   (mode_hi_crc)
    );

    // soft-reset request bit, must survive its own reset
    rw_reg #(.T_DATA(logic), .DEFAULT_VAL(1'b0), .CRC_W(1)) u_mode_lo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (wr_sel[SEL_MODE]),
        .i_wdata (i_wdata[0]),
        .i_wcrc  (i_wcrc[0]),
        .o_data  (mode_lo),
        .o_crc   (mode_lo_crc)
    );

    rw_reg #(.T_DATA(reg_data_t), .DEFAULT_VAL(DEF_CONFIG1), .CRC_W(REG_CRC_W)) u_config1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_CONFIG1]),
        .i_wdata (i_wdata),
        .i_wcrc  (i_wcrc),
        .o_data  (o_reg_config1),
        .o_crc   (config1_crc)
    );

    rw_reg #(.T_DATA(reg_data_t), .DEFAULT_VAL(DEF_CONFIG2), .CRC_W(REG_CRC_W)) u_config2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_CONFIG2]),
        .i_wdata (i_wdata),
        .i_wcrc  (i_wcrc),
        .o_data  (o_reg_config2),
        .o_crc   (config2_crc)
    );

    rw_reg #(.T_DATA(reg_data_t), .DEFAULT_VAL(DEF_MASK), .CRC_W(REG_CRC_W)) u_mask1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_MASK1]),
        .i_wdata (i_wdata),
        .i_wcrc  (i_wcrc),
        .o_data  (o_reg_mask1),
        .o_crc   (mask1_crc)
    );

    rw_reg #(.T_DATA(reg_data_t), .DEFAULT_VAL(DEF_MASK), .CRC_W(REG_CRC_W)) u_mask2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_MASK2]),
        .i_wdata (i_wdata),
        .i_wcrc  (i_wcrc),
        .o_data  (o_reg_mask2),
        .o_crc   (mask2_crc)
    );

    rwc_reg u_status1 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_STATUS1]),
        .i_wdata (i_wdata),
        .i_set   (i_int_status1),
        .o_data  (o_reg_status1)
    );

    rwc_reg u_status2 (
        .i_clk   (i_clk),
        .i_rst_n (rst_n),
        .i_we    (wr_sel[SEL_STATUS2]),
        .i_wdata (i_wdata),
        .i_set   (i_int_status2),
        .o_data  (o_reg_status2)
    );

    // ========================================
    // read return and reset merge
    // ========================================
    reg_read_return u_reg_read_return (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_ren         (i_ren),
        .i_rd_sel      (rd_sel),
        .i_mode        (o_reg_mode),
        .i_mode_crc    ({mode_hi_crc, mode_lo_crc}),
        .i_config1     (o_reg_config1),
        .i_config1_crc (config1_crc),
        .i_config2     (o_reg_config2),
        .i_config2_crc (config2_crc),
        .i_status1     (o_reg_status1),
        .i_mask1       (o_reg_mask1),
        .i_mask1_crc   (mask1_crc),
        .i_status2     (o_reg_status2),
        .i_mask2       (o_reg_mask2),
        .i_mask2_crc   (mask2_crc),
        .o_rack        (o_rack),
        .o_rdata       (o_rdata),
        .o_rcrc        (o_rcrc)
    );

    rstn_merge u_rstn_merge (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_soft_rst (mode_lo),
        .o_rst_n    (rst_n)
    );

endmodule

// ==== include/tb_reg_bank_tests.svh ====
// included inside tb_reg_bank; uses its signals, bus tasks and compare tasks directly
`ifndef TB_REG_BANK_TESTS_SVH
`define TB_REG_BANK_TESTS_SVH

    // write grant from the register table
    function automatic bit write_allowed(input reg_addr_t a, input bit t, input bit c, input bit s);
        case (a)
            7'h01:                      return t | c | s;
            7'h02, 7'h03, 7'h09, 7'h0B: return t | c;
            7'h08, 7'h0A:               return c | s;
            default:                    return 1'b0;
        endcase
    endfunction

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset_defaults();
        reg_addr_t addrs [10];
        reg_data_t exp [10];
        begin_test("reset_defaults");
        addrs = '{7'h00, 7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h04, 7'h7F};
        exp   = '{8'h5A, 8'h08, 8'h2B, 8'hFF, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        check_bit("internal reset", 1'b1, soft_rst_n);
        check_bit("read ack", 1'b0, rack);
        check_data("read data", 8'h00, rdata);
        check_crc("read crc", 8'h00, rcrc);
        check_data("mode out", 8'h08, reg_mode);
        set_modes(1'b1, 1'b0, 1'b0);
        // back-to-back strobes, each result one cycle behind
        for (int i = 0; i <= 10; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_bit($sformatf("read ack 0x%02h", addrs[i-1]), 1'b1, rack);
                check_data($sformatf("read data 0x%02h", addrs[i-1]), exp[i-1], rdata);
                check_crc($sformatf("read crc 0x%02h", addrs[i-1]), 8'h00, rcrc);
            end
            if (i < 10) begin
                ren  = 1'b1;
                addr = addrs[i];
            end else begin
                ren = 1'b0;
            end
        end
        end_test();
    endtask

    task automatic test_write_readback();
        reg_addr_t addrs [4];
        reg_data_t d [4];
        reg_crc_t  c [4];
        begin_test("write_readback");
        addrs = '{ADDR_CONFIG1, ADDR_CONFIG2, ADDR_MASK1, ADDR_MASK2};
        set_modes(1'b1, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            d[i] = reg_data_t'($urandom);
            c[i] = reg_crc_t'($urandom);
            bus_write(addrs[i], d[i], c[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_expect(addrs[i], d[i], c[i]);
        end
        check_data("config1 out", d[0], reg_config1);
        check_data("config2 out", d[1], reg_config2);
        check_data("mask1 out", d[2], reg_mask1);
        check_data("mask2 out", d[3], reg_mask2);
        end_test();
    endtask

    task automatic test_permissions();
        reg_data_t old;
        bit        ok;
        begin_test("permissions");
        // configuration mode writes but never reads
        set_modes(1'b0, 1'b1, 1'b0);
        read_expect(ADDR_CONFIG1, 8'h00, 8'h00);
        read_expect(ADDR_DEVICE_ID, 8'h00, 8'h00);
        old = reg_config1;
        ok  = write_allowed(ADDR_CONFIG1, 1'b0, 1'b1, 1'b0);
        bus_write(ADDR_CONFIG1, 8'h3C, 8'hC3);
        @(negedge clk);
        check_data("config1 by cfg write", ok ? 8'h3C : old, reg_config1);
        // spi mode
        set_modes(1'b0, 1'b0, 1'b1);
        old = reg_config2;
        ok  = write_allowed(ADDR_CONFIG2, 1'b0, 1'b0, 1'b1);
        bus_write(ADDR_CONFIG2, 8'h11, 8'h22);
        @(negedge clk);
        check_data("config2 by spi write", ok ? 8'h11 : old, reg_config2);
        ok = write_allowed(ADDR_MODE, 1'b0, 1'b0, 1'b1);
        bus_write(ADDR_MODE, 8'h10, 8'h5A);
        read_expect(ADDR_MODE, ok ? 8'h10 : 8'h08, ok ? 8'h5A : 8'h00);
        // the device id stays constant with every mode open
        set_modes(1'b1, 1'b1, 1'b1);
        bus_write(ADDR_DEVICE_ID, 8'hFF, 8'hFF);
        read_expect(ADDR_DEVICE_ID, 8'h5A, 8'h00);
        end_test();
    endtask

    task automatic test_status_sticky();
        begin_test("status_sticky");
        set_modes(1'b0, 1'b0, 1'b1);
        int_status1 = 8'hA5;
        int_status2 = 8'h3C;
        @(negedge clk);
        int_status1 = 8'h00;
        int_status2 = 8'h00;
        @(negedge clk);
        check_data("status1 held", 8'hA5, reg_status1);
        check_data("status2 held", 8'h3C, reg_status2);
        read_expect(ADDR_STATUS1, 8'hA5, 8'h00);
        bus_write(ADDR_STATUS1, 8'h05, 8'hEE);
        read_expect(ADDR_STATUS1, 8'hA0, 8'h00);
        check_data("status2 after status1 clear", 8'h3C, reg_status2);
        // bit 2 set again in the clear cycle
        int_status2 = 8'h04;
        bus_write(ADDR_STATUS2, 8'h0C, 8'h00);
        @(negedge clk);
        int_status2 = 8'h00;
        read_expect(ADDR_STATUS2, 8'h34, 8'h00);
        set_modes(1'b1, 1'b0, 1'b0);
        bus_write(ADDR_STATUS1, 8'hA0, 8'h00);
        read_expect(ADDR_STATUS1,
                    write_allowed(ADDR_STATUS1, 1'b1, 1'b0, 1'b0) ? 8'h00 : 8'hA0, 8'h00);
        end_test();
    endtask

    task automatic test_soft_reset();
        int cycles;
        begin_test("soft_reset");
        set_modes(1'b1, 1'b0, 1'b0);
        bus_write(ADDR_CONFIG1, 8'h66, 8'h99);
        read_expect(ADDR_CONFIG1, 8'h66, 8'h99);
        bus_write(ADDR_MODE, 8'h01, 8'h01);
        @(negedge clk);
        check_bit("internal reset low", 1'b0, soft_rst_n);
        check_data("config1 in reset", 8'h2B, reg_config1);
        read_expect(ADDR_CONFIG1, 8'h2B, 8'h00);
        bus_write(ADDR_CONFIG1, 8'h77, 8'h88);
        read_expect(ADDR_CONFIG1, 8'h2B, 8'h00);
        // upper mode bits sit at default, bit 0 and its crc bit kept
        read_expect(ADDR_MODE, 8'h09, 8'h01);
        bus_write(ADDR_MODE, 8'h00, 8'h00);
        // count edges after the write edge
        cycles = 1;
        @(negedge clk);
        while (soft_rst_n !== 1'b1 && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        check_bit("internal reset released", 1'b1, soft_rst_n);
        checks++;
        if (cycles > 2) begin
            errors++;
            $display("%s: internal reset released after %0d cycles, later than two",
                     test_name, cycles);
        end
        read_expect(ADDR_MODE, 8'h08, 8'h00);
        bus_write(ADDR_CONFIG1, 8'h77, 8'h88);
        read_expect(ADDR_CONFIG1, 8'h77, 8'h88);
        end_test();
    endtask

`endif

// ==== tb/tb_reg_bank.sv ====
// directed tests from include/; drives on the falling edge, never a read and a write together
`timescale 1ns/1ps

module tb_reg_bank;
    import reg_bank_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int EXPECTED_CYCLES = 400;
    localparam int WATCHDOG_CYCLES = 2 * EXPECTED_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      ren;
    logic      wen;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_crc_t  wcrc;
    logic      test_en;
    logic      cfg_en;
    logic      spi_en;
    reg_data_t int_status1;
    reg_data_t int_status2;
    logic      wack;
    logic      rack;
    reg_data_t rdata;
    reg_crc_t  rcrc;
    reg_data_t reg_mode;
    reg_data_t reg_config1;
    reg_data_t reg_config2;
    reg_data_t reg_status1;
    reg_data_t reg_mask1;
    reg_data_t reg_status2;
    reg_data_t reg_mask2;
    logic      soft_rst_n;

    string test_name;
    int    seed = 14;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    checks = 0;
    int    errors = 0;

    reg_bank_top u_reg_bank_top (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_ren         (ren),
        .i_wen         (wen),
        .i_addr        (addr),
        .i_wdata       (wdata),
        .i_wcrc        (wcrc),
        .i_test_en     (test_en),
        .i_cfg_en      (cfg_en),
        .i_spi_en      (spi_en),
        .i_int_status1 (int_status1),
        .i_int_status2 (int_status2),
        .o_wack        (wack),
        .o_rack        (rack),
        .o_rdata       (rdata),
        .o_rcrc        (rcrc),
        .o_reg_mode    (reg_mode),
        .o_reg_config1 (reg_config1),
        .o_reg_config2 (reg_config2),
        .o_reg_status1 (reg_status1),
        .o_reg_mask1   (reg_mask1),
        .o_reg_status2 (reg_status2),
        .o_reg_mask2   (reg_mask2),
        .o_rst_n       (soft_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected 0x%02h actual 0x%02h", test_name, what, exp, act);
        end
    endtask

    task automatic check_crc(input string what, input reg_crc_t exp, input reg_crc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected 0x%02h actual 0x%02h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic print_counts();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
    endtask

    // ========================================
    // bus tasks
    // ========================================
    task automatic set_modes(input logic t, input logic c, input logic s);
        @(negedge clk);
        test_en = t;
        cfg_en  = c;
        spi_en  = s;
    endtask

    // returns just after the edge that follows the strobe
    task automatic bus_write(input reg_addr_t a, input reg_data_t d, input reg_crc_t c);
        @(negedge clk);
        wen   = 1'b1;
        addr  = a;
        wdata = d;
        wcrc  = c;
        @(posedge clk);
        check_bit("write ack", 1'b1, wack);
        @(negedge clk);
        wen = 1'b0;
        @(posedge clk);
        check_bit("write ack idle", 1'b0, wack);
    endtask

    task automatic bus_read(input reg_addr_t a, output logic ack, output reg_data_t d,
                            output reg_crc_t c);
        @(negedge clk);
        ren  = 1'b1;
        addr = a;
        @(negedge clk);
        ren = 1'b0;
        ack = rack;
        d   = rdata;
        c   = rcrc;
    endtask

    task automatic read_expect(input reg_addr_t a, input reg_data_t exp_d, input reg_crc_t exp_c);
        logic      ack;
        reg_data_t d;
        reg_crc_t  c;
        bus_read(a, ack, d, c);
        check_bit($sformatf("read ack 0x%02h", a), 1'b1, ack);
        check_data($sformatf("read data 0x%02h", a), exp_d, d);
        check_crc($sformatf("read crc 0x%02h", a), exp_c, c);
    endtask

    `include "tb_reg_bank_tests.svh"

    initial begin
        void'($urandom(seed));
        rst_n       = 1'b0;
        ren         = 1'b0;
        wen         = 1'b0;
        addr        = '0;
        wdata       = '0;
        wcrc        = '0;
        test_en     = 1'b0;
        cfg_en      = 1'b0;
        spi_en      = 1'b0;
        int_status1 = '0;
        int_status2 = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // internal reset follows two edges later
        repeat (2) @(negedge clk);
        test_reset_defaults();
        test_write_readback();
        test_permissions();
        test_status_sticky();
        test_soft_reset();
        print_counts();
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, test did not finish");
        print_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
logic/reg_bank_pkg.sv
logic/rw_reg.sv
logic/rwc_reg.sv
logic/reg_access_decode.sv
logic/reg_read_return.sv
logic/rstn_merge.sv
logic/reg_bank_top.sv
tb/tb_reg_bank.sv
